// File: src/core_pkg.sv
`default_nettype none

package core_pkg;

	////////////////////////////////////////
	// Widths
	////////////////////////////////////////

	localparam int data_w     = 16;
	localparam int reg_addr_w = 4;
	localparam int num_regs   = 16;
	localparam int imm_w      = 8;
	localparam int page_w     = 8;

	////////////////////////////////////////
	// Opcodes
	////////////////////////////////////////

	// Codes 9 to 15 are illegal
	typedef enum logic [3:0] {
		OP_NOP  = 4'h0,
		OP_ADD  = 4'h1,
		OP_SUB  = 4'h2,
		OP_AND  = 4'h3,
		OP_OR   = 4'h4,
		OP_XOR  = 4'h5,
		OP_SLL  = 4'h6,
		OP_LI   = 4'h7,
		OP_ADDI = 4'h8
	} opcode_t;

	typedef struct packed {
		logic [3:0]            opcode;
		logic [reg_addr_w-1:0] rd;
		logic [reg_addr_w-1:0] rs;
		logic [reg_addr_w-1:0] rt;
	} r_fmt_t;

	typedef struct packed {
		logic [3:0]            opcode;
		logic [reg_addr_w-1:0] rd;
		logic [imm_w-1:0]      imm8;
	} i_fmt_t;

	// Same 16 bits, register or immediate view
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
	} inst_word_u;

	////////////////////////////////////////
	// LED pages
	////////////////////////////////////////

	typedef enum logic [page_w-1:0] {
		PAGE_STATUS      = 8'h00,
		PAGE_INST        = 8'h01,
		PAGE_FIELDS      = 8'h02,
		PAGE_OP_A        = 8'h03,
		PAGE_OP_B        = 8'h04,
		PAGE_RESULT      = 8'h05,
		PAGE_ILLEGAL_CNT = 8'h06,
		PAGE_REG_BASE    = 8'h10
	} led_page_t;

endpackage

`default_nettype wire

// File: src/decode_if.sv
`timescale 1ns/1ns
`default_nettype none

// One decoded instruction, decode to execute
interface decode_if;

	logic                              valid;
	logic                              ready;
	core_pkg::opcode_t                 op;
	logic [core_pkg::reg_addr_w-1:0]   rd;
	logic [core_pkg::reg_addr_w-1:0]   rs;
	logic [core_pkg::reg_addr_w-1:0]   rt;
	logic [core_pkg::imm_w-1:0]        imm;
	core_pkg::inst_word_u              word;

	modport producer (
		output valid,
		output op,
		output rd,
		output rs,
		output rt,
		output imm,
		output word,
		input  ready
	);

	modport consumer (
		input  valid,
		input  op,
		input  rd,
		input  rs,
		input  rt,
		input  imm,
		input  word,
		output ready
	);

endinterface

`default_nettype wire

// File: src/inst_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module inst_decoder (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        inst_valid,
	output logic                        inst_ready,
	input  core_pkg::inst_word_u        inst_word,
	decode_if.producer                  dec,
	output logic [core_pkg::data_w-1:0] illegal_cnt,
	output logic                        decoder_error,
	output core_pkg::inst_word_u        last_word
);

	function automatic logic is_legal(input logic [3:0] code);
		case (code)
			core_pkg::OP_NOP,
			core_pkg::OP_ADD,
			core_pkg::OP_SUB,
			core_pkg::OP_AND,
			core_pkg::OP_OR,
			core_pkg::OP_XOR,
			core_pkg::OP_SLL,
			core_pkg::OP_LI,
			core_pkg::OP_ADDI: return 1'b1;
			default:           return 1'b0;
		endcase
	endfunction

	logic                            stage_valid;
	logic                            load;
	logic                            legal;
	logic                            imm_fmt;
	logic [3:0]                      code;
	core_pkg::opcode_t               op_q;
	logic [core_pkg::reg_addr_w-1:0] rd_q;
	logic [core_pkg::reg_addr_w-1:0] rs_q;
	logic [core_pkg::reg_addr_w-1:0] rt_q;
	logic [core_pkg::imm_w-1:0]      imm_q;
	core_pkg::inst_word_u            word_q;

	// Stage accepts when empty or handing on
	assign inst_ready = !stage_valid || dec.ready;
	assign load       = inst_valid && inst_ready;
	assign code       = inst_word.r_fmt.opcode;
	assign legal      = is_legal(code);
	assign imm_fmt    = (code == core_pkg::OP_LI) || (code == core_pkg::OP_ADDI);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			stage_valid   <= 1'b0;
			illegal_cnt   <= '0;
			decoder_error <= 1'b0;
		end else begin
			if (load) begin
				stage_valid <= legal;
			end else if (dec.ready) begin
				stage_valid <= 1'b0;
			end
			// Illegal words stop here
			if (load && !legal) begin
				decoder_error <= 1'b1;
				if (illegal_cnt != '1) begin
					illegal_cnt <= illegal_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			last_word <= inst_word;
		end
		if (load && legal) begin
			op_q   <= core_pkg::opcode_t'(code);
			rd_q   <= inst_word.r_fmt.rd;
			word_q <= inst_word;
			if (imm_fmt) begin
				rs_q  <= '0;
				rt_q  <= '0;
				imm_q <= inst_word.i_fmt.imm8;
			end else begin
				rs_q  <= inst_word.r_fmt.rs;
				rt_q  <= inst_word.r_fmt.rt;
				imm_q <= '0;
			end
		end
	end

	assign dec.valid = stage_valid;
	assign dec.op    = op_q;
	assign dec.rd    = rd_q;
	assign dec.rs    = rs_q;
	assign dec.rt    = rt_q;
	assign dec.imm   = imm_q;
	assign dec.word  = word_q;

	a_dec_legal: assert property (@(posedge clk) disable iff (!rst_n)
		dec.valid |-> is_legal(dec.op))
		else $error("illegal opcode reached execute");

endmodule

`default_nettype wire

// File: src/register_file.sv
`timescale 1ns/1ns
`default_nettype none

module register_file (
	input  logic                                           clk,
	input  logic                                           rst_n,
	input  logic [core_pkg::reg_addr_w-1:0]                rd_addr_a,
	input  logic [core_pkg::reg_addr_w-1:0]                rd_addr_b,
	output logic [core_pkg::data_w-1:0]                    rd_data_a,
	output logic [core_pkg::data_w-1:0]                    rd_data_b,
	input  logic                                           wr_en,
	input  logic [core_pkg::reg_addr_w-1:0]                wr_addr,
	input  logic [core_pkg::data_w-1:0]                    wr_data,
	output logic [core_pkg::num_regs*core_pkg::data_w-1:0] debug_flat
);

	logic [core_pkg::data_w-1:0] regs [core_pkg::num_regs];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < core_pkg::num_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Reads see the old value during a write
	assign rd_data_a = regs[rd_addr_a];
	assign rd_data_b = regs[rd_addr_b];

	// r0 in the low word
	for (genvar g = 0; g < core_pkg::num_regs; g++) begin : g_flat
		assign debug_flat[g*core_pkg::data_w +: core_pkg::data_w] = regs[g];
	end

endmodule

`default_nettype wire

// File: src/exec_unit.sv
`timescale 1ns/1ns
`default_nettype none

module exec_unit (
	input  logic                            clk,
	input  logic                            rst_n,
	decode_if.consumer                      dec,
	output logic [core_pkg::reg_addr_w-1:0] rd_addr_a,
	output logic [core_pkg::reg_addr_w-1:0] rd_addr_b,
	input  logic [core_pkg::data_w-1:0]     rd_data_a,
	input  logic [core_pkg::data_w-1:0]     rd_data_b,
	output logic                            wr_en,
	output logic [core_pkg::reg_addr_w-1:0] wr_addr,
	output logic [core_pkg::data_w-1:0]     wr_data,
	output logic                            res_valid,
	input  logic                            res_ready,
	output logic [core_pkg::reg_addr_w-1:0] res_rd,
	output logic [core_pkg::data_w-1:0]     res_data,
	output logic [core_pkg::data_w-1:0]     op_a,
	output logic [core_pkg::data_w-1:0]     op_b
);

	localparam int ext_w = core_pkg::data_w - core_pkg::imm_w;

	logic                        accept;
	logic                        has_result;
	logic [core_pkg::data_w-1:0] opnd_a;
	logic [core_pkg::data_w-1:0] opnd_b;
	logic [core_pkg::data_w-1:0] result;

	// Result register empty or draining this cycle
	assign dec.ready  = !res_valid || res_ready;
	assign accept     = dec.valid && dec.ready;
	assign has_result = (dec.op != core_pkg::OP_NOP);

	////////////////////////////////////////
	// Operands
	////////////////////////////////////////

	// ADDI accumulates into rd
	assign rd_addr_a = (dec.op == core_pkg::OP_ADDI) ? dec.rd : dec.rs;
	assign rd_addr_b = dec.rt;
	assign opnd_a    = rd_data_a;

	always_comb begin
		case (dec.op)
			core_pkg::OP_LI:   opnd_b = {{ext_w{1'b0}}, dec.imm};
			core_pkg::OP_ADDI: opnd_b = {{ext_w{dec.imm[core_pkg::imm_w-1]}}, dec.imm};
			default:           opnd_b = rd_data_b;
		endcase
	end

	always_comb begin
		case (dec.op)
			core_pkg::OP_ADD:  result = opnd_a + opnd_b;
			core_pkg::OP_SUB:  result = opnd_a - opnd_b;
			core_pkg::OP_AND:  result = opnd_a & opnd_b;
			core_pkg::OP_OR:   result = opnd_a | opnd_b;
			core_pkg::OP_XOR:  result = opnd_a ^ opnd_b;
			core_pkg::OP_SLL:  result = opnd_a << opnd_b[3:0];
			core_pkg::OP_LI:   result = opnd_b;
			core_pkg::OP_ADDI: result = opnd_a + opnd_b;
			default:           result = '0;
		endcase
	end

	////////////////////////////////////////
	// Write-back and result
	////////////////////////////////////////

	// Single write per instruction, at acceptance
	assign wr_en   = accept && has_result;
	assign wr_addr = dec.rd;
	assign wr_data = result;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			res_valid <= 1'b0;
		end else if (accept && has_result) begin
			res_valid <= 1'b1;
		end else if (res_ready) begin
			res_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept && has_result) begin
			res_rd   <= dec.rd;
			res_data <= result;
			op_a     <= opnd_a;
			op_b     <= opnd_b;
		end
	end

	a_res_hold: assert property (@(posedge clk) disable iff (!rst_n)
		res_valid && !res_ready |=> res_valid && $stable(res_data) && $stable(res_rd))
		else $error("result changed while stalled");

	// Decode must hold its stage while we stall it
	a_dec_hold: assert property (@(posedge clk) disable iff (!rst_n)
		dec.valid && !dec.ready |=> dec.valid && $stable(dec.word))
		else $error("decode stage dropped a stalled instruction");

endmodule

`default_nettype wire

// File: src/led_debug_mux.sv
`timescale 1ns/1ns
`default_nettype none

module led_debug_mux (
	input  logic [15:0]                                    sw,
	output logic [15:0]                                    led,
	input  logic                                           inst_valid,
	input  logic                                           inst_ready,
	input  logic                                           dec_valid,
	input  logic                                           res_valid,
	input  logic                                           res_ready,
	input  logic                                           decoder_error,
	input  core_pkg::inst_word_u                           last_word,
	input  logic [core_pkg::data_w-1:0]                    illegal_cnt,
	input  logic [core_pkg::data_w-1:0]                    op_a,
	input  logic [core_pkg::data_w-1:0]                    op_b,
	input  logic [core_pkg::data_w-1:0]                    res_data,
	input  logic [core_pkg::reg_addr_w-1:0]                res_rd,
	input  logic [core_pkg::num_regs*core_pkg::data_w-1:0] debug_flat
);

	logic [core_pkg::page_w-1:0] page;
	logic                        reg_page;
	logic                        imm_word;

	assign page     = sw[15:8];
	assign reg_page = (page & 8'hF0) == core_pkg::PAGE_REG_BASE;

	// Immediate words carry no rs or rt
	assign imm_word = (last_word.i_fmt.opcode == core_pkg::OP_LI) ||
		(last_word.i_fmt.opcode == core_pkg::OP_ADDI);

	always_comb begin
		case (page)
			// Flags on odd bits, last result's rd in the low nibble
			core_pkg::PAGE_STATUS: led = {
				inst_valid, 1'b0,
				inst_ready, 1'b0,
				dec_valid, 1'b0,
				res_valid, 1'b0,
				res_ready, 1'b0,
				decoder_error, 1'b0,
				res_rd
			};
			core_pkg::PAGE_INST:        led = last_word;
			core_pkg::PAGE_FIELDS: led = {
				last_word.r_fmt.opcode,
				last_word.r_fmt.rd,
				imm_word ? 8'h00 : {last_word.r_fmt.rs, last_word.r_fmt.rt}
			};
			core_pkg::PAGE_OP_A:        led = op_a;
			core_pkg::PAGE_OP_B:        led = op_b;
			core_pkg::PAGE_RESULT:      led = res_data;
			core_pkg::PAGE_ILLEGAL_CNT: led = illegal_cnt;
			default: begin
				if (reg_page) begin
					led = debug_flat[page[3:0]*core_pkg::data_w +: core_pkg::data_w];
				end else begin
					led = sw;
				end
			end
		endcase
	end

endmodule

`default_nettype wire

// File: src/core_top.sv
`timescale 1ns/1ns
`default_nettype none

module core_top (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            inst_valid,
	output logic                            inst_ready,
	input  logic [core_pkg::data_w-1:0]     inst_word,
	output logic                            res_valid,
	input  logic                            res_ready,
	output logic [core_pkg::reg_addr_w-1:0] res_rd,
	output logic [core_pkg::data_w-1:0]     res_data,
	input  logic [15:0]                     sw,
	output logic [15:0]                     led
);

	logic [core_pkg::reg_addr_w-1:0]                rd_addr_a;
	logic [core_pkg::reg_addr_w-1:0]                rd_addr_b;
	logic [core_pkg::data_w-1:0]                    rd_data_a;
	logic [core_pkg::data_w-1:0]                    rd_data_b;
	logic                                           wr_en;
	logic [core_pkg::reg_addr_w-1:0]                wr_addr;
	logic [core_pkg::data_w-1:0]                    wr_data;
	logic [core_pkg::num_regs*core_pkg::data_w-1:0] debug_flat;
	logic [core_pkg::data_w-1:0]                    illegal_cnt;
	logic                                           decoder_error;
	core_pkg::inst_word_u                           last_word;
	logic [core_pkg::data_w-1:0]                    op_a;
	logic [core_pkg::data_w-1:0]                    op_b;

	decode_if dec_ch ();

	inst_decoder u_decoder (
		.clk           (clk),
		.rst_n         (rst_n),
		.inst_valid    (inst_valid),
		.inst_ready    (inst_ready),
		.inst_word     (inst_word),
		.dec           (dec_ch),
		.illegal_cnt   (illegal_cnt),
		.decoder_error (decoder_error),
		.last_word     (last_word)
	);

	register_file u_regs (
		.clk        (clk),
		.rst_n      (rst_n),
		.rd_addr_a  (rd_addr_a),
		.rd_addr_b  (rd_addr_b),
		.rd_data_a  (rd_data_a),
		.rd_data_b  (rd_data_b),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.debug_flat (debug_flat)
	);

	exec_unit u_exec (
		.clk       (clk),
		.rst_n     (rst_n),
		.dec       (dec_ch),
		.rd_addr_a (rd_addr_a),
		.rd_addr_b (rd_addr_b),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.res_valid (res_valid),
		.res_ready (res_ready),
		.res_rd    (res_rd),
		.res_data  (res_data),
		.op_a      (op_a),
		.op_b      (op_b)
	);

	led_debug_mux u_led (
		.sw            (sw),
		.led           (led),
		.inst_valid    (inst_valid),
		.inst_ready    (inst_ready),
		.dec_valid     (dec_ch.valid),
		.res_valid     (res_valid),
		.res_ready     (res_ready),
		.decoder_error (decoder_error),
		.last_word     (last_word),
		.illegal_cnt   (illegal_cnt),
		.op_a          (op_a),
		.op_b          (op_b),
		.res_data      (res_data),
		.res_rd        (res_rd),
		.debug_flat    (debug_flat)
	);

endmodule

`default_nettype wire

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	localparam int period_ns    = 4;
	localparam int reset_cycles = 5;

	initial begin
		clk = 1'b0;
		forever #(period_ns / 2) clk = ~clk;
	end

	// Release on a falling edge, away from the sampling edge
	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// File: sim/tb_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_core;

	localparam int num_rows       = 28;
	localparam int steady_rows    = 12;
	localparam int reset_cycles   = 5;
	localparam int timeout_cycles = num_rows * 20 + reset_cycles;

	logic        clk;
	logic        rst_n;
	logic        inst_valid;
	logic        inst_ready;
	logic [15:0] inst_word;
	logic        res_valid;
	logic        res_ready;
	logic [3:0]  res_rd;
	logic [15:0] res_data;
	logic [15:0] sw;
	logic [15:0] led;

	// Stimulus table: word, result flag, rd, value
	logic [15:0] table_word [num_rows];
	logic        table_has  [num_rows];
	logic [3:0]  table_rd   [num_rows];
	logic [15:0] table_val  [num_rows];
	logic [15:0] model_regs [16];
	logic [3:0]  exp_rd_q [$];
	logic [15:0] exp_val_q [$];

	int seed;
	int pass_cnt;
	int fail_cnt;
	int illegal_rows;
	int steady_results;
	int result_cnt;
	int extra_cnt;
	bit sender_done;

	tb_clock_gen u_clk (
		.clk   (clk),
		.rst_n (rst_n)
	);

	core_top i_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.inst_valid (inst_valid),
		.inst_ready (inst_ready),
		.inst_word  (inst_word),
		.res_valid  (res_valid),
		.res_ready  (res_ready),
		.res_rd     (res_rd),
		.res_data   (res_data),
		.sw         (sw),
		.led        (led)
	);

	task automatic check_value(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		if (actual === expected) begin
			pass_cnt++;
			$display("[PASS] %s", name);
		end else begin
			fail_cnt++;
			$display("[FAIL] %s expected %h actual %h", name, expected, actual);
		end
	endtask

	////////////////////////////////////////
	// Table and register model
	////////////////////////////////////////

	task automatic fill_table();
		table_word = '{
			// Immediates, then dependent register ops
			16'h7105, 16'h72F3, 16'h82FE, 16'h8380, 16'h7403, 16'h1512,
			16'h2651, 16'h3763, 16'h4874, 16'h5983, 16'h6A94, 16'h6B1A,
			// NOPs and illegal words mixed with stalls
			16'h0000, 16'h7F7F, 16'h9ABC, 16'h1FF1, 16'h80FF, 16'h20F0,
			16'hF000, 16'h0123, 16'h5DAB, 16'h3E0D, 16'h6CD1, 16'h4C0C,
			16'h8C01, 16'hA5A5, 16'h1112, 16'h7A00
		};
	endtask

	task automatic run_model();
		logic [3:0]  op;
		logic [3:0]  rd;
		logic [7:0]  imm;
		logic [15:0] a;
		logic [15:0] b;
		for (int i = 0; i < 16; i++) begin
			model_regs[i] = '0;
		end
		for (int r = 0; r < num_rows; r++) begin
			op  = table_word[r][15:12];
			rd  = table_word[r][11:8];
			imm = table_word[r][7:0];
			a   = model_regs[table_word[r][7:4]];
			b   = model_regs[table_word[r][3:0]];
			table_has[r] = 1'b1;
			table_rd[r]  = rd;
			case (op)
				core_pkg::OP_ADD:  table_val[r] = a + b;
				core_pkg::OP_SUB:  table_val[r] = a - b;
				core_pkg::OP_AND:  table_val[r] = a & b;
				core_pkg::OP_OR:   table_val[r] = a | b;
				core_pkg::OP_XOR:  table_val[r] = a ^ b;
				core_pkg::OP_SLL:  table_val[r] = a << b[3:0];
				core_pkg::OP_LI:   table_val[r] = {8'h00, imm};
				core_pkg::OP_ADDI: table_val[r] = model_regs[rd] + {{8{imm[7]}}, imm};
				default: begin
					table_has[r] = 1'b0;
					table_val[r] = '0;
					if (op != core_pkg::OP_NOP) begin
						illegal_rows++;
					end
				end
			endcase
			if (table_has[r]) begin
				model_regs[rd] = table_val[r];
				exp_rd_q.push_back(table_rd[r]);
				exp_val_q.push_back(table_val[r]);
				if (r < steady_rows) begin
					steady_results++;
				end
			end
		end
	endtask

	////////////////////////////////////////
	// Sender and receiver
	////////////////////////////////////////

	task automatic send_table();
		for (int r = 0; r < num_rows; r++) begin
			@(negedge clk);
			inst_valid = 1'b1;
			inst_word  = table_word[r];
			#1;
			while (!inst_ready) begin
				@(negedge clk);
				#1;
			end
		end
		@(negedge clk);
		inst_valid  = 1'b0;
		sender_done = 1'b1;
	endtask

	task automatic receive_results();
		logic [31:0] rnd;
		int          exp_total;
		exp_total = exp_val_q.size();
		while (result_cnt < exp_total) begin
			@(negedge clk);
			// Ready held high for the first block, random after it
			if (result_cnt < steady_results) begin
				res_ready = 1'b1;
			end else begin
				rnd       = $random(seed);
				res_ready = rnd[0];
			end
			#1;
			if (res_valid && res_ready) begin
				check_value($sformatf("result %0d rd", result_cnt),
					{12'h000, exp_rd_q[result_cnt]}, {12'h000, res_rd});
				check_value($sformatf("result %0d data", result_cnt),
					exp_val_q[result_cnt], res_data);
				result_cnt++;
			end
		end
		wait (sender_done);
		// Duplicates would show up here
		repeat (10) begin
			@(negedge clk);
			res_ready = 1'b1;
			#1;
			if (res_valid) begin
				extra_cnt++;
			end
		end
		check_value("result count", 16'(exp_total), 16'(result_cnt + extra_cnt));
	endtask

	task automatic check_led_pages();
		logic [7:0] page;
		@(negedge clk);
		sw = {core_pkg::PAGE_ILLEGAL_CNT, 8'h00};
		#1;
		check_value("illegal count page", 16'(illegal_rows), led);
		@(negedge clk);
		sw = {core_pkg::PAGE_STATUS, 8'h00};
		#1;
		check_value("status decoder_error", 16'h0001, {15'h0000, led[5]});
		for (int i = 0; i < 16; i++) begin
			@(negedge clk);
			page = core_pkg::PAGE_REG_BASE + 8'(i);
			sw   = {page, 8'hC3};
			#1;
			check_value($sformatf("register page r%0d", i), model_regs[i], led);
		end
		@(negedge clk);
		sw = 16'h7E5A;
		#1;
		check_value("undefined page passthrough", 16'h7E5A, led);
	endtask

	////////////////////////////////////////
	// Main sequence and watchdog
	////////////////////////////////////////

	initial begin
		inst_valid = 1'b0;
		inst_word  = '0;
		res_ready  = 1'b0;
		sw         = '0;
		seed       = 32'hfa95;
		fill_table();
		run_model();
		@(posedge rst_n);
		#1;
		check_value("reset inst_ready", 16'h0001, {15'h0000, inst_ready});
		check_value("reset res_valid", 16'h0000, {15'h0000, res_valid});
		fork
			send_table();
			receive_results();
		join
		check_led_pages();
		$display("Checks: %0d passed, %0d failed", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	initial begin
		repeat (timeout_cycles) @(posedge clk);
		$display("Run timed out after %0d cycles before all results arrived", timeout_cycles);
		$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
src/core_pkg.sv
src/decode_if.sv
src/inst_decoder.sv
src/register_file.sv
src/exec_unit.sv
src/led_debug_mux.sv
src/core_top.sv
sim/tb_clock_gen.sv
sim/tb_core.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the core testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal --top-module tb_core -f build.f -o sim_core

./obj_dir/sim_core 2>&1 | tee sim.log

if grep -q 'All tests passed!' sim.log; then
	echo "Simulation PASSED"
	exit 0
else
	echo "Simulation FAILED"
	exit 1
fi
